// ==== Makefile ====
# Verilator build and run for the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

.DEFAULT_GOAL := check

all: check

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)

check: run
	@if grep -qx 'STATUS: PASS' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
design/mem_pkg.sv
design/pmp_pkg.sv
design/pmp_checker.sv
design/mem_arbiter.sv
design/sram_memory.sv
design/mem_subsystem.sv
testbench/tb_mem_subsystem.sv

// ==== design/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            imem_valid,
  input  mem_pkg::priv_mode               imem_mode,
  input  logic [mem_pkg::xlen-1:0]        imem_addr,
  input  logic [mem_pkg::xlen-1:0]        imem_wdata,
  input  logic [mem_pkg::strb_width-1:0]  imem_wstrb,
  output logic                            imem_ready,
  output logic                            imem_error,
  output logic [mem_pkg::xlen-1:0]        imem_rdata,
  input  logic                            dmem_valid,
  input  mem_pkg::priv_mode               dmem_mode,
  input  logic [mem_pkg::xlen-1:0]        dmem_addr,
  input  logic [mem_pkg::xlen-1:0]        dmem_wdata,
  input  logic [mem_pkg::strb_width-1:0]  dmem_wstrb,
  output logic                            dmem_ready,
  output logic                            dmem_error,
  output logic [mem_pkg::xlen-1:0]        dmem_rdata,
  output mem_pkg::priv_mode               chk_mode,
  output logic [mem_pkg::xlen-1:0]        chk_addr,
  output mem_pkg::access_kind             chk_kind,
  input  logic                            chk_error,
  output logic                            memory_valid,
  output logic [mem_pkg::xlen-1:0]        memory_addr,
  output logic [mem_pkg::xlen-1:0]        memory_wdata,
  output logic [mem_pkg::strb_width-1:0]  memory_wstrb,
  input  logic [mem_pkg::xlen-1:0]        memory_rdata,
  input  logic                            memory_ready
);
  import mem_pkg::*;

  typedef enum logic [1:0] {
    own_none = 2'b00,
    own_imem = 2'b01,
    own_dmem = 2'b10
  } owner_t;

  // registered record of the granted request
  owner_t                r_owner;
  logic                  r_error;
  logic [xlen-1:0]       r_addr;
  logic [xlen-1:0]       r_wdata;
  logic [strb_width-1:0] r_wstrb;

  // candidate from the requester side
  owner_t                cand_owner;
  priv_mode              cand_mode;
  logic [xlen-1:0]       cand_addr;
  logic [xlen-1:0]       cand_wdata;
  logic [strb_width-1:0] cand_wstrb;
  access_kind            cand_kind;
  logic                  grant;

  logic                  resp_ready;
  logic [xlen-1:0]       resp_rdata;

  ////////////////////////////////////////////////////////////
  // grant and check
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (dmem_valid) begin
      cand_owner = own_dmem;
      cand_mode  = dmem_mode;
      cand_addr  = dmem_addr;
      cand_wdata = dmem_wdata;
      cand_wstrb = dmem_wstrb;
      cand_kind  = (|dmem_wstrb) ? acc_write : acc_read;
    end else begin
      cand_owner = own_imem;
      cand_mode  = imem_mode;
      cand_addr  = imem_addr;
      cand_wdata = imem_wdata;
      cand_wstrb = imem_wstrb;
      cand_kind  = acc_exec;
    end
  end

  assign grant = (r_owner == own_none) && (dmem_valid || imem_valid);

  // checker sees machine mode outside the grant cycle
  assign chk_mode = grant ? cand_mode : m_mode;
  assign chk_addr = cand_addr;
  assign chk_kind = cand_kind;

  ////////////////////////////////////////////////////////////
  // memory side
  ////////////////////////////////////////////////////////////

  always_comb begin
    memory_valid = 1'b0;
    memory_addr  = '0;
    memory_wdata = '0;
    memory_wstrb = '0;
    if (grant && !chk_error) begin
      memory_valid = 1'b1;
      memory_addr  = cand_addr;
      memory_wdata = cand_wdata;
      memory_wstrb = cand_wstrb;
    end else if (r_owner != own_none && !r_error) begin
      memory_valid = 1'b1;
      memory_addr  = r_addr;
      memory_wdata = r_wdata;
      memory_wstrb = r_wstrb;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      r_owner <= own_none;
      r_error <= 1'b0;
    end else if (grant) begin
      r_owner <= cand_owner;
      r_error <= chk_error;
    end else if (r_owner != own_none && (r_error || memory_ready)) begin
      r_owner <= own_none;
      r_error <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin
      r_addr  <= cand_addr;
      r_wdata <= cand_wdata;
      r_wstrb <= cand_wstrb;
    end
  end

  ////////////////////////////////////////////////////////////
  // response routing
  ////////////////////////////////////////////////////////////

  // refused access answers one cycle after grant with zero data
  assign resp_ready = r_error ? 1'b1 : memory_ready;
  assign resp_rdata = r_error ? '0 : memory_rdata;

  assign imem_ready = (r_owner == own_imem) && resp_ready;
  assign imem_error = (r_owner == own_imem) && r_error;
  assign imem_rdata = (r_owner == own_imem) ? resp_rdata : '0;

  assign dmem_ready = (r_owner == own_dmem) && resp_ready;
  assign dmem_error = (r_owner == own_dmem) && r_error;
  assign dmem_rdata = (r_owner == own_dmem) ? resp_rdata : '0;

  a_no_valid_on_error: assert property (
    @(posedge clk) disable iff (!rst)
    !(memory_valid && chk_error)
  ) else $error("mem_arbiter: refused access reached memory");

endmodule

`default_nettype wire

// ==== design/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  ////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////

  localparam int xlen = 32;

  // one strobe bit per byte lane
  localparam int strb_width = xlen / 8;

  ////////////////////////////////////////////////////////////
  // request attributes
  ////////////////////////////////////////////////////////////

  // privilege of the requester, riscv encoding
  typedef enum logic [1:0] {
    u_mode = 2'b00,
    m_mode = 2'b11
  } priv_mode;

  // what the access does, as seen by the protection check
  typedef enum logic [1:0] {
    acc_read  = 2'b00,
    acc_write = 2'b01,
    acc_exec  = 2'b10
  } access_kind;

endpackage

`default_nettype wire

// ==== design/mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem #(
  parameter int num_regions    = 4,
  parameter int mem_words_log2 = 8,
  parameter int mem_wait       = 2
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            imem_valid,
  input  mem_pkg::priv_mode               imem_mode,
  input  logic [mem_pkg::xlen-1:0]        imem_addr,
  input  logic [mem_pkg::xlen-1:0]        imem_wdata,
  input  logic [mem_pkg::strb_width-1:0]  imem_wstrb,
  output logic                            imem_ready,
  output logic                            imem_error,
  output logic [mem_pkg::xlen-1:0]        imem_rdata,
  input  logic                            dmem_valid,
  input  mem_pkg::priv_mode               dmem_mode,
  input  logic [mem_pkg::xlen-1:0]        dmem_addr,
  input  logic [mem_pkg::xlen-1:0]        dmem_wdata,
  input  logic [mem_pkg::strb_width-1:0]  dmem_wstrb,
  output logic                            dmem_ready,
  output logic                            dmem_error,
  output logic [mem_pkg::xlen-1:0]        dmem_rdata,
  input  logic                            cfg_we,
  input  pmp_pkg::region_idx_t            cfg_index,
  input  logic [mem_pkg::xlen-1:0]        cfg_base,
  input  logic [mem_pkg::xlen-1:0]        cfg_limit,
  input  pmp_pkg::perm_t                  cfg_perm
);
  import mem_pkg::*;

  // check link
  priv_mode              chk_mode;
  logic [xlen-1:0]       chk_addr;
  access_kind            chk_kind;
  logic                  chk_error;

  // memory link
  logic                  memory_valid;
  logic [xlen-1:0]       memory_addr;
  logic [xlen-1:0]       memory_wdata;
  logic [strb_width-1:0] memory_wstrb;
  logic [xlen-1:0]       memory_rdata;
  logic                  memory_ready;

  mem_arbiter u_arbiter (
    .clk          (clk),
    .rst          (rst),
    .imem_valid   (imem_valid),
    .imem_mode    (imem_mode),
    .imem_addr    (imem_addr),
    .imem_wdata   (imem_wdata),
    .imem_wstrb   (imem_wstrb),
    .imem_ready   (imem_ready),
    .imem_error   (imem_error),
    .imem_rdata   (imem_rdata),
    .dmem_valid   (dmem_valid),
    .dmem_mode    (dmem_mode),
    .dmem_addr    (dmem_addr),
    .dmem_wdata   (dmem_wdata),
    .dmem_wstrb   (dmem_wstrb),
    .dmem_ready   (dmem_ready),
    .dmem_error   (dmem_error),
    .dmem_rdata   (dmem_rdata),
    .chk_mode     (chk_mode),
    .chk_addr     (chk_addr),
    .chk_kind     (chk_kind),
    .chk_error    (chk_error),
    .memory_valid (memory_valid),
    .memory_addr  (memory_addr),
    .memory_wdata (memory_wdata),
    .memory_wstrb (memory_wstrb),
    .memory_rdata (memory_rdata),
    .memory_ready (memory_ready)
  );

  pmp_checker #(
    .num_regions (num_regions)
  ) u_pmp (
    .clk       (clk),
    .rst       (rst),
    .cfg_we    (cfg_we),
    .cfg_index (cfg_index),
    .cfg_base  (cfg_base),
    .cfg_limit (cfg_limit),
    .cfg_perm  (cfg_perm),
    .chk_mode  (chk_mode),
    .chk_addr  (chk_addr),
    .chk_kind  (chk_kind),
    .chk_error (chk_error)
  );

  sram_memory #(
    .mem_words_log2 (mem_words_log2),
    .mem_wait       (mem_wait)
  ) u_sram (
    .clk          (clk),
    .rst          (rst),
    .memory_valid (memory_valid),
    .memory_addr  (memory_addr),
    .memory_wdata (memory_wdata),
    .memory_wstrb (memory_wstrb),
    .memory_rdata (memory_rdata),
    .memory_ready (memory_ready)
  );

endmodule

`default_nettype wire

// ==== design/pmp_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module pmp_checker #(
  parameter int num_regions = 4
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         cfg_we,
  input  pmp_pkg::region_idx_t         cfg_index,
  input  logic [mem_pkg::xlen-1:0]     cfg_base,
  input  logic [mem_pkg::xlen-1:0]     cfg_limit,
  input  pmp_pkg::perm_t               cfg_perm,
  input  mem_pkg::priv_mode            chk_mode,
  input  logic [mem_pkg::xlen-1:0]     chk_addr,
  input  mem_pkg::access_kind          chk_kind,
  output logic                         chk_error
);
  import mem_pkg::*;
  import pmp_pkg::*;

  localparam int idx_bits = (num_regions > 1) ? $clog2(num_regions) : 1;

  logic [xlen-1:0]     region_base  [num_regions];
  logic [xlen-1:0]     region_limit [num_regions];
  perm_t               region_perm  [num_regions];
  logic [idx_bits-1:0] wr_idx;
  logic                wr_in_range;
  logic                hit_found;
  perm_t               hit_perm;
  logic                kind_allowed;

  if (num_regions < 1 || num_regions > max_regions) begin : g_bad_region_count
    $error("pmp_checker: num_regions out of range");
  end

  ////////////////////////////////////////////////////////////
  // region table
  ////////////////////////////////////////////////////////////

  assign wr_idx      = cfg_index[idx_bits-1:0];
  assign wr_in_range = int'(cfg_index) < num_regions;

  // empty range and no permissions out of reset
  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < num_regions; i++) begin
        region_base[i]  <= '0;
        region_limit[i] <= '0;
        region_perm[i]  <= '0;
      end
    end else if (cfg_we && wr_in_range) begin
      region_base[wr_idx]  <= cfg_base;
      region_limit[wr_idx] <= cfg_limit;
      region_perm[wr_idx]  <= cfg_perm;
    end
  end

  ////////////////////////////////////////////////////////////
  // permission check
  ////////////////////////////////////////////////////////////

  always_comb begin
    hit_found = 1'b0;
    hit_perm  = '0;
    // walk downwards so the lowest matching region wins
    for (int i = num_regions - 1; i >= 0; i--) begin
      if (chk_addr >= region_base[i] && chk_addr < region_limit[i]) begin
        hit_found = 1'b1;
        hit_perm  = region_perm[i];
      end
    end

    case (chk_kind)
      acc_read:  kind_allowed = hit_perm[perm_r];
      acc_write: kind_allowed = hit_perm[perm_w];
      acc_exec:  kind_allowed = hit_perm[perm_x];
      default:   kind_allowed = 1'b0;
    endcase

    // machine mode bypasses the table, unmatched user access is refused
    chk_error = (chk_mode != m_mode) && !(hit_found && kind_allowed);
  end

  a_cfg_index_range: assert property (
    @(posedge clk) disable iff (!rst)
    cfg_we |-> (int'(cfg_index) < num_regions)
  ) else $error("pmp_checker: cfg_index beyond configured regions");

endmodule

`default_nettype wire

// ==== design/pmp_pkg.sv ====
`default_nettype none

package pmp_pkg;

  ////////////////////////////////////////////////////////////
  // region permissions
  ////////////////////////////////////////////////////////////

  typedef logic [2:0] perm_t;

  // bit positions inside perm_t
  localparam int perm_r = 0;
  localparam int perm_w = 1;
  localparam int perm_x = 2;

  ////////////////////////////////////////////////////////////
  // region table bounds
  ////////////////////////////////////////////////////////////

  // upper bound on table size, fixes the index width
  localparam int max_regions = 16;

  typedef logic [$clog2(max_regions)-1:0] region_idx_t;

endpackage

`default_nettype wire

// ==== design/sram_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_memory #(
  parameter int mem_words_log2 = 8,
  parameter int mem_wait       = 2
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            memory_valid,
  input  logic [mem_pkg::xlen-1:0]        memory_addr,
  input  logic [mem_pkg::xlen-1:0]        memory_wdata,
  input  logic [mem_pkg::strb_width-1:0]  memory_wstrb,
  output logic [mem_pkg::xlen-1:0]        memory_rdata,
  output logic                            memory_ready
);
  import mem_pkg::*;

  localparam int depth       = 1 << mem_words_log2;
  localparam int offset_bits = $clog2(strb_width);
  localparam int cnt_width   = $clog2(mem_wait + 1);

  logic [xlen-1:0]           mem_array [depth];
  logic [mem_words_log2-1:0] word_idx;
  logic [cnt_width-1:0]      wait_cnt;
  logic                      ready_q;
  logic [xlen-1:0]           rdata_q;

  if (mem_wait < 1) begin : g_bad_wait
    $error("sram_memory: mem_wait must be at least 1");
  end

  // word index wraps at the depth
  assign word_idx = memory_addr[offset_bits +: mem_words_log2];

  ////////////////////////////////////////////////////////////
  // wait counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst) begin
      wait_cnt <= '0;
      ready_q  <= 1'b0;
    end else if (memory_valid && !ready_q) begin
      wait_cnt <= wait_cnt + 1'b1;
      ready_q  <= (wait_cnt + 1'b1) == cnt_width'(mem_wait);
    end else begin
      // ready cycle or idle, next valid starts a new count
      wait_cnt <= '0;
      ready_q  <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (memory_valid && !ready_q) begin
      rdata_q <= mem_array[word_idx];
    end
    if (memory_valid && ready_q) begin
      for (int lane = 0; lane < strb_width; lane++) begin
        if (memory_wstrb[lane]) begin
          mem_array[word_idx][8*lane +: 8] <= memory_wdata[8*lane +: 8];
        end
      end
    end
  end

  assign memory_ready = ready_q;
  assign memory_rdata = rdata_q;

  a_addr_stable: assert property (
    @(posedge clk) disable iff (!rst)
    (memory_valid && !memory_ready) |=> $stable(memory_addr)
  ) else $error("sram_memory: address changed before ready");

endmodule

`default_nettype wire

// ==== testbench/tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;
  import mem_pkg::*;
  import pmp_pkg::*;

  localparam int num_regions    = 4;
  localparam int mem_words_log2 = 8;
  localparam int mem_wait       = 2;
  localparam int depth          = 1 << mem_words_log2;
  localparam int n_random       = 60;
  localparam int n_both         = 4;
  localparam int n_rounds       = 4;
  localparam int n_user         = 30;
  localparam int n_fixed        = 8;
  localparam int num_trans      = depth + 2 * n_random + 2 * n_both
                                  + 2 * n_rounds * n_user + n_fixed;
  localparam int timeout_cycles = num_trans * (mem_wait + 4) * 2;

  logic                  clk;
  logic                  rst;
  logic                  imem_valid;
  priv_mode              imem_mode;
  logic [xlen-1:0]       imem_addr;
  logic [xlen-1:0]       imem_wdata;
  logic [strb_width-1:0] imem_wstrb;
  logic                  imem_ready;
  logic                  imem_error;
  logic [xlen-1:0]       imem_rdata;
  logic                  dmem_valid;
  priv_mode              dmem_mode;
  logic [xlen-1:0]       dmem_addr;
  logic [xlen-1:0]       dmem_wdata;
  logic [strb_width-1:0] dmem_wstrb;
  logic                  dmem_ready;
  logic                  dmem_error;
  logic [xlen-1:0]       dmem_rdata;
  logic                  cfg_we;
  region_idx_t           cfg_index;
  logic [xlen-1:0]       cfg_base;
  logic [xlen-1:0]       cfg_limit;
  perm_t                 cfg_perm;

  // reference model state
  logic [xlen-1:0] model_mem   [depth];
  logic [xlen-1:0] model_base  [num_regions];
  logic [xlen-1:0] model_limit [num_regions];
  perm_t           model_perm  [num_regions];

  integer seed = 44;
  int     error_count = 0;
  int     check_count = 0;
  int     cycle_count = 0;
  int     dmem_ready_cycle;
  int     imem_ready_cycle;
  logic   dmem_busy = 1'b0;
  logic   imem_busy = 1'b0;
  logic   dmem_last_error;
  logic   imem_last_error;

  mem_subsystem #(
    .num_regions    (num_regions),
    .mem_words_log2 (mem_words_log2),
    .mem_wait       (mem_wait)
  ) u_dut (
    .clk        (clk),
    .rst        (rst),
    .imem_valid (imem_valid),
    .imem_mode  (imem_mode),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .imem_wstrb (imem_wstrb),
    .imem_ready (imem_ready),
    .imem_error (imem_error),
    .imem_rdata (imem_rdata),
    .dmem_valid (dmem_valid),
    .dmem_mode  (dmem_mode),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .dmem_ready (dmem_ready),
    .dmem_error (dmem_error),
    .dmem_rdata (dmem_rdata),
    .cfg_we     (cfg_we),
    .cfg_index  (cfg_index),
    .cfg_base   (cfg_base),
    .cfg_limit  (cfg_limit),
    .cfg_perm   (cfg_perm)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  ////////////////////////////////////////////////////////////
  // checking helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [xlen-1:0] expected,
                             input logic [xlen-1:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("failure at %0t: %s", $time, what);
  endtask

  // first matching region from index 0 upwards decides
  function automatic logic access_denied(input priv_mode mode, input logic [xlen-1:0] addr,
                                         input access_kind kind);
    int    i;
    int    hit;
    perm_t perm;
    hit = -1;
    for (i = 0; i < num_regions; i++) begin
      if (hit < 0 && addr >= model_base[i] && addr < model_limit[i]) begin
        hit = i;
      end
    end
    if (mode == m_mode) return 1'b0;
    if (hit < 0) return 1'b1;
    perm = model_perm[hit];
    case (kind)
      acc_read:  return !perm[perm_r];
      acc_write: return !perm[perm_w];
      acc_exec:  return !perm[perm_x];
      default:   return 1'b1;
    endcase
  endfunction

  task automatic apply_write(input logic [mem_words_log2-1:0] idx,
                             input logic [xlen-1:0] wdata,
                             input logic [strb_width-1:0] wstrb);
    int lane;
    for (lane = 0; lane < strb_width; lane++) begin
      if (wstrb[lane]) begin
        model_mem[idx][8*lane +: 8] = wdata[8*lane +: 8];
      end
    end
  endtask

  function automatic logic [xlen-1:0] random_word();
    return $random(seed);
  endfunction

  function automatic logic [xlen-1:0] random_word_addr();
    logic [xlen-1:0] r;
    logic [xlen-1:0] addr;
    r    = $random(seed);
    addr = '0;
    addr[mem_words_log2+1:2] = r[mem_words_log2-1:0];
    return addr;
  endfunction

  // both ports at once, or a ready nobody asked for
  always @(negedge clk) begin
    if (rst === 1'b1) begin
      if (imem_ready === 1'b1 && dmem_ready === 1'b1) begin
        report_failure("ready was raised on both ports in the same cycle");
      end
      if (imem_ready === 1'b1 && !imem_busy) begin
        report_failure("imem ready arrived without an outstanding request");
      end
      if (dmem_ready === 1'b1 && !dmem_busy) begin
        report_failure("dmem ready arrived without an outstanding request");
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // requester and configuration drivers
  ////////////////////////////////////////////////////////////

  task automatic dmem_access(input priv_mode mode, input logic [xlen-1:0] addr,
                             input logic [xlen-1:0] wdata,
                             input logic [strb_width-1:0] wstrb);
    access_kind                kind;
    logic                      exp_error;
    logic [mem_words_log2-1:0] idx;
    kind       = (wstrb != '0) ? acc_write : acc_read;
    idx        = addr[mem_words_log2+1:2];
    dmem_busy  = 1'b1;
    dmem_mode  = mode;
    dmem_addr  = addr;
    dmem_wdata = wdata;
    dmem_wstrb = wstrb;
    dmem_valid = 1'b1;
    @(negedge clk);
    while (dmem_ready !== 1'b1) @(negedge clk);
    dmem_ready_cycle = cycle_count;
    dmem_last_error  = dmem_error;
    exp_error = access_denied(mode, addr, kind);
    check_value("dmem_error", 32'(exp_error), 32'(dmem_error));
    if (exp_error) begin
      check_value("dmem_rdata", '0, dmem_rdata);
    end else if (kind == acc_read) begin
      check_value("dmem_rdata", model_mem[idx], dmem_rdata);
    end else begin
      apply_write(idx, wdata, wstrb);
    end
    @(posedge clk);
    #1;
    dmem_valid = 1'b0;
    dmem_wstrb = '0;
    dmem_busy  = 1'b0;
  endtask

  task automatic imem_access(input priv_mode mode, input logic [xlen-1:0] addr);
    logic                      exp_error;
    logic [mem_words_log2-1:0] idx;
    idx        = addr[mem_words_log2+1:2];
    imem_busy  = 1'b1;
    imem_mode  = mode;
    imem_addr  = addr;
    imem_valid = 1'b1;
    @(negedge clk);
    while (imem_ready !== 1'b1) @(negedge clk);
    imem_ready_cycle = cycle_count;
    imem_last_error  = imem_error;
    exp_error = access_denied(mode, addr, acc_exec);
    check_value("imem_error", 32'(exp_error), 32'(imem_error));
    check_value("imem_rdata", exp_error ? '0 : model_mem[idx], imem_rdata);
    @(posedge clk);
    #1;
    imem_valid = 1'b0;
    imem_busy  = 1'b0;
  endtask

  task automatic random_dmem_op(input logic user_allowed);
    logic [xlen-1:0] r;
    priv_mode        mode;
    r    = random_word();
    mode = (user_allowed && r[1:0] != 2'b00) ? u_mode : m_mode;
    if (r[2]) begin
      dmem_access(mode, random_word_addr(), random_word(), r[7:4]);
    end else begin
      dmem_access(mode, random_word_addr(), random_word(), '0);
    end
  endtask

  task automatic random_imem_op(input logic user_allowed);
    logic [xlen-1:0] r;
    priv_mode        mode;
    r    = random_word();
    mode = (user_allowed && r[1:0] != 2'b00) ? u_mode : m_mode;
    imem_access(mode, random_word_addr());
  endtask

  task automatic write_region(input region_idx_t idx, input logic [xlen-1:0] base,
                              input logic [xlen-1:0] limit, input perm_t perm);
    cfg_we           = 1'b1;
    cfg_index        = idx;
    cfg_base         = base;
    cfg_limit        = limit;
    cfg_perm         = perm;
    model_base[idx]  = base;
    model_limit[idx] = limit;
    model_perm[idx]  = perm;
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
  endtask

  task automatic configure_random_regions();
    logic [xlen-1:0] r;
    logic [xlen-1:0] base;
    int              i;
    for (i = 0; i < num_regions; i++) begin
      r    = random_word();
      base = random_word_addr();
      write_region(region_idx_t'(i), base, base + (32'(r[5:0]) << 2) + 32'd4, r[8:6]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int i;
    rst        = 1'b0;
    imem_valid = 1'b0;
    imem_mode  = m_mode;
    imem_addr  = '0;
    imem_wdata = '0;
    imem_wstrb = '0;
    dmem_valid = 1'b0;
    dmem_mode  = m_mode;
    dmem_addr  = '0;
    dmem_wdata = '0;
    dmem_wstrb = '0;
    cfg_we     = 1'b0;
    cfg_index  = '0;
    cfg_base   = '0;
    cfg_limit  = '0;
    cfg_perm   = '0;
    for (i = 0; i < num_regions; i++) begin
      model_base[i]  = '0;
      model_limit[i] = '0;
      model_perm[i]  = '0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b1;

    // idle outputs with no request
    repeat (4) begin
      @(negedge clk);
      check_value("imem_ready", '0, 32'(imem_ready));
      check_value("imem_error", '0, 32'(imem_error));
      check_value("dmem_ready", '0, 32'(dmem_ready));
      check_value("dmem_error", '0, 32'(dmem_error));
    end
    @(posedge clk);
    #1;

    // whole memory filled in machine mode
    for (i = 0; i < depth; i++) begin
      dmem_access(m_mode, 32'(i) << 2, random_word(), '1);
    end

    fork
      repeat (n_random) random_dmem_op(1'b0);
      repeat (n_random) random_imem_op(1'b0);
    join

    // same-cycle requests, data port first
    repeat (n_both) begin
      fork
        random_dmem_op(1'b0);
        random_imem_op(1'b0);
      join
      if (dmem_ready_cycle >= imem_ready_cycle) begin
        report_failure("imem was answered before dmem after requests in the same cycle");
      end
    end

    repeat (n_rounds) begin
      configure_random_regions();
      fork
        repeat (n_user) random_dmem_op(1'b1);
        repeat (n_user) random_imem_op(1'b1);
      join
    end

    // read-only region, user write must not land
    write_region(region_idx_t'(0), 32'h100, 32'h200, 3'b001);
    dmem_access(m_mode, 32'h140, '0, '0);
    dmem_access(u_mode, 32'h140, random_word(), '1);
    check_value("refused write error", 32'd1, 32'(dmem_last_error));
    dmem_access(m_mode, 32'h140, '0, '0);

    write_region(region_idx_t'(0), 32'h300, 32'h380, 3'b000);
    imem_access(u_mode, 32'h310);
    check_value("fetch error before reconfig", 32'd1, 32'(imem_last_error));
    write_region(region_idx_t'(0), 32'h300, 32'h380, 3'b100);
    imem_access(u_mode, 32'h310);
    check_value("fetch error after reconfig", 32'd0, 32'(imem_last_error));
    dmem_access(u_mode, 32'h320, '0, '0);
    check_value("read error without r", 32'd1, 32'(dmem_last_error));
    write_region(region_idx_t'(0), 32'h300, 32'h380, 3'b101);
    dmem_access(u_mode, 32'h320, '0, '0);
    check_value("read error with r", 32'd0, 32'(dmem_last_error));

    repeat (3) @(posedge clk);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
